// ==== source/agc_bus_pkg.sv ====
package agc_bus_pkg;

    typedef logic [15:0] word_t;          // CPU write bus word
    typedef logic [2:0]  stage_t;         // ST3..ST1

    typedef struct packed {
        logic t12;
        logic t11;
        logic t10;
        logic t09;
        logic t08;
        logic t07;
        logic t06;
        logic t05;
        logic t04;
        logic t03;
        logic t02;
        logic t01;                        // Bit 0
    } tp_t;

    // Field order gives the SQ scan word directly when shifted up by 9
    typedef struct packed {
        logic sqext;
        logic sq16;
        logic sq14;
        logic sq13;
        logic sq12;
        logic sq11;
        logic sq10;
    } sq_t;

    typedef struct packed {
        logic wag;
        logic wlg;
        logic wqg;
        logic wzg;
        logic wbbeg;
        logic webg;
        logic wfbg;
        logic wg;
        logic rgg;                        // G reloaded from the bus on a read as well
        logic wsg;
        logic wbg;
    } wstrobe_t;

    localparam stage_t STAGE_0 = 3'o0;
    localparam stage_t STAGE_1 = 3'o1;

    localparam logic [1:0] FIXED_SWITCHED = 2'b01;  // S in 2000..3777
    localparam logic [1:0] FEB_BANKS      = 2'b11;  // FB in 30..37, FEB applies

endpackage

// ==== source/mon_reg_pkg.sv ====
package mon_reg_pkg;

    typedef logic [4:0] ir_t;

    localparam ir_t IR_BYPASS  = 5'o00;
    localparam ir_t IR_CONTROL = 5'o02;
    localparam ir_t IR_BRKBANK = 5'o03;
    localparam ir_t IR_BRKADDR = 5'o04;
    localparam ir_t IR_RWBANK  = 5'o05;
    localparam ir_t IR_RWADDR  = 5'o06;
    localparam ir_t IR_RWDATA  = 5'o10;
    localparam ir_t IR_REG_A   = 5'o20;
    localparam ir_t IR_REG_L   = 5'o21;
    localparam ir_t IR_REG_Q   = 5'o22;
    localparam ir_t IR_REG_Z   = 5'o23;
    localparam ir_t IR_REG_BB  = 5'o24;
    localparam ir_t IR_REG_G   = 5'o25;
    localparam ir_t IR_REG_SQ  = 5'o26;
    localparam ir_t IR_REG_S   = 5'o27;
    localparam ir_t IR_REG_B   = 5'o30;

    typedef struct packed {
        logic [4:0] spare_hi;             // Bits 15:11
        logic       nhalga;               // Bit 10
        logic [2:0] spare_lo;             // Bits 9:7, held the channel requests
        logic       store;
        logic       fetch;
        logic       break_inst;
        logic       step_type;
        logic       step;
        logic       mstrt;
        logic       mstp;                 // Bit 0
    } control_t;

    localparam logic STEP_INST = 1'b1;
    localparam logic STEP_MCT  = 1'b0;

    // Host word as shifted in: bit 15 doubles as write enable except for RWDATA
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic        wen;
            logic [14:0] payload;
        } wr;
    } scan_word_u;

    typedef struct packed {
        control_t    control;
        logic [15:0] break_bank;
        logic [15:0] break_addr;
        logic [15:0] rw_bank;
        logic [15:0] rw_addr;
        logic [15:0] rw_data;
    } mon_file_t;

    typedef struct packed {
        logic [15:0] a;
        logic [15:0] l;
        logic [15:0] q;
        logic [15:0] z;
        logic [15:0] bb;
        logic [15:0] g;
        logic [15:0] s;
        logic [15:0] b;
        logic [15:0] sq;
    } shadow_t;

endpackage

// ==== source/scan_port.sv ====
module scan_port import agc_bus_pkg::*, mon_reg_pkg::*; (
    input  logic       SIM_CLK,
    input  logic       rst_n,
    input  logic       tdi,
    input  ir_t        ir,
    input  logic       capture,
    input  logic       shift,
    input  logic       update,
    input  mon_file_t  regs,
    input  shadow_t    shadow,
    output logic       tdo,
    output logic       upd,
    output ir_t        upd_ir,
    output scan_word_u upd_word
);

    scan_word_u shreg;                    // Data register being shifted
    logic       bypass_bit;
    word_t      cap_word;

    always_comb begin
        case (ir)
            IR_CONTROL: cap_word = regs.control;
            IR_BRKBANK: cap_word = regs.break_bank;
            IR_BRKADDR: cap_word = regs.break_addr;
            IR_RWBANK:  cap_word = regs.rw_bank;
            IR_RWADDR:  cap_word = regs.rw_addr;
            IR_RWDATA:  cap_word = regs.rw_data;
            IR_REG_A:   cap_word = shadow.a;
            IR_REG_L:   cap_word = shadow.l;
            IR_REG_Q:   cap_word = shadow.q;
            IR_REG_Z:   cap_word = shadow.z;
            IR_REG_BB:  cap_word = shadow.bb;
            IR_REG_G:   cap_word = shadow.g;
            IR_REG_SQ:  cap_word = shadow.sq;
            IR_REG_S:   cap_word = shadow.s;
            IR_REG_B:   cap_word = shadow.b;
            default:    cap_word = '0;    // Unknown codes read back as zero
        endcase
    end

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            shreg      <= '0;
            bypass_bit <= 1'b0;
            upd        <= 1'b0;
            upd_ir     <= IR_BYPASS;
        end else begin
            upd <= update;
            if (update) begin
                upd_ir <= ir;
            end
            if (ir == IR_BYPASS) begin
                if (shift) begin
                    bypass_bit <= tdi;
                end
            end else if (capture) begin
                shreg.raw <= cap_word;
            end else if (shift) begin
                shreg.raw <= {tdi, shreg.raw[15:1]};  // LSB first out
            end
        end
    end

    assign tdo      = (ir == IR_BYPASS) ? bypass_bit : shreg.raw[0];
    assign upd_word = shreg;

    // Host side must issue one strobe per cycle at most
    a_one_strobe: assert property (@(posedge SIM_CLK) disable iff (!rst_n)
        $onehot0({capture, shift, update}));

endmodule

// ==== source/mon_regs.sv ====
module mon_regs import agc_bus_pkg::*, mon_reg_pkg::*; (
    input  logic       SIM_CLK,
    input  logic       rst_n,
    input  logic       upd,
    input  ir_t        upd_ir,
    input  scan_word_u upd_word,
    input  word_t      wbus,
    input  logic       rw_load,
    input  logic       step_done,
    input  logic       fetch_done,
    input  logic       store_done,
    input  logic       hit,
    output mon_file_t  regs
);

    logic wr_en;                          // Update with the write-enable bit set

    assign wr_en = upd && upd_word.wr.wen;

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            // Host update first
            if (wr_en) begin
                case (upd_ir)
                    IR_CONTROL: regs.control[14:0]    <= upd_word.wr.payload;
                    IR_BRKBANK: regs.break_bank[14:0] <= upd_word.wr.payload;
                    IR_BRKADDR: regs.break_addr[14:0] <= upd_word.wr.payload;
                    IR_RWBANK:  regs.rw_bank[14:0]    <= upd_word.wr.payload;
                    IR_RWADDR:  regs.rw_addr[14:0]    <= upd_word.wr.payload;
                    default:    ;
                endcase
            end
            if (upd && upd_ir == IR_RWDATA) begin
                regs.rw_data[14:0] <= upd_word.wr.payload;  // No write-enable bit here
            end

            // Controller and breakpoint win over a same-cycle host write
            if (rw_load) begin
                regs.rw_data <= wbus;     // Fetched word from the CPU
            end
            if (step_done) begin
                regs.control.step <= 1'b0;
            end
            if (fetch_done) begin
                regs.control.fetch <= 1'b0;
            end
            if (store_done) begin
                regs.control.store <= 1'b0;
            end
            if (hit) begin
                regs.control.mstp <= 1'b1;
            end
        end
    end

    // Only one monitor sequence can finish at a time
    a_single_done: assert property (@(posedge SIM_CLK) disable iff (!rst_n)
        !(fetch_done && store_done));

endmodule

// ==== source/cpu_shadow.sv ====
module cpu_shadow import agc_bus_pkg::*, mon_reg_pkg::*; (
    input  logic     SIM_CLK,
    input  logic     rst_n,
    input  word_t    wbus,
    input  wstrobe_t wstr,
    input  sq_t      sq,
    output shadow_t  shadow
);

    word_t       a_r;
    word_t       l_r;
    word_t       q_r;
    word_t       z_r;
    word_t       bb_r;                    // FB in 14:10, EB in 2:0
    word_t       g_r;
    logic [11:0] s_r;
    word_t       b_r;

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            a_r  <= '0;
            l_r  <= '0;
            q_r  <= '0;
            z_r  <= '0;
            bb_r <= '0;
            g_r  <= '0;
            s_r  <= '0;
            b_r  <= '0;
        end else begin
            if (wstr.wag) begin
                a_r <= wbus;
            end
            if (wstr.wlg) begin
                l_r <= wbus;
            end
            if (wstr.wqg) begin
                q_r <= wbus;
            end
            if (wstr.wzg) begin
                z_r <= wbus;
            end
            if (wstr.wbbeg) begin
                bb_r[14]    <= wbus[15];  // Bus bit 15 is the true sign
                bb_r[13:10] <= wbus[13:10];
                bb_r[2:0]   <= wbus[2:0];
            end
            if (wstr.webg) begin
                bb_r[2:0] <= wbus[10:8];
            end
            if (wstr.wfbg) begin
                bb_r[14]    <= wbus[15];
                bb_r[13:10] <= wbus[13:10];
            end
            if (wstr.wg || wstr.rgg) begin
                g_r <= wbus;
            end
            if (wstr.wsg) begin
                s_r <= wbus[11:0];
            end
            if (wstr.wbg) begin
                b_r <= wbus;
            end
        end
    end

    assign shadow = '{a: a_r, l: l_r, q: q_r, z: z_r, bb: bb_r, g: g_r,
                      s: {4'b0, s_r}, b: b_r, sq: {sq, 9'b0}};

endmodule

// ==== source/break_detect.sv ====
module break_detect import agc_bus_pkg::*, mon_reg_pkg::*; (
    input  shadow_t   shadow,
    input  mon_file_t regs,
    input  logic      mnisq,
    output logic      hit
);

    logic addr_match;
    logic fixed_sw;                       // S points into the fixed-switched window
    logic feb_used;
    logic bank_match;

    assign addr_match = shadow.s[11:0] == regs.break_addr[11:0];
    assign fixed_sw   = shadow.s[11:10] == FIXED_SWITCHED;
    assign feb_used   = shadow.bb[14:13] == FEB_BANKS;

    // Upper fixed banks also need the FEB bits to agree
    assign bank_match = feb_used ? (shadow.bb[14:4] == regs.break_bank[14:4])
                                 : (shadow.bb[14:10] == regs.break_bank[14:10]);

    assign hit = regs.control.break_inst && mnisq && addr_match
                 && (!fixed_sw || bank_match);

endmodule

// ==== source/seq_ctrl.sv ====
module seq_ctrl import agc_bus_pkg::*, mon_reg_pkg::*; (
    input  logic      SIM_CLK,
    input  logic      rst_n,
    input  mon_file_t regs,
    input  tp_t       tp,
    input  stage_t    stage,
    input  logic      mnisq,
    input  logic      mreqin,
    output word_t     mdt,
    output logic      mread,
    output logic      mload,
    output logic      suppress,
    output logic      rw_load,
    output logic      step_done,
    output logic      fetch_done,
    output logic      store_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQUEST,                        // MREAD or MLOAD up, waiting for MREQIN
        S_ACTIVE
    } state_t;

    state_t state;
    logic   seq_req;
    logic   seq_run;
    logic   in_st0;
    logic   in_st1;
    logic   fetch;
    logic   store;

    assign fetch   = regs.control.fetch;
    assign store   = regs.control.store;
    assign seq_req = fetch || store;
    assign seq_run = seq_req && (state == S_ACTIVE || (state == S_REQUEST && mreqin));
    assign in_st0  = seq_run && stage == STAGE_0;
    assign in_st1  = seq_run && stage == STAGE_1;

    assign step_done  = regs.control.step
                        && ((tp.t01 && regs.control.step_type == STEP_MCT)
                            || (mnisq && regs.control.step_type == STEP_INST));
    assign rw_load    = in_st1 && fetch && tp.t07;
    assign fetch_done = in_st1 && fetch && tp.t11;
    assign store_done = in_st1 && !fetch && tp.t11;  // FETCH wins if both are set

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            mdt      <= '0;
            mread    <= 1'b0;
            mload    <= 1'b0;
            suppress <= 1'b0;
        end else begin
            if (step_done) begin
                suppress <= 1'b0;
            end else if (regs.control.step) begin
                suppress <= 1'b1;
            end

            case (state)
                S_IDLE:    state <= seq_req ? S_REQUEST : S_IDLE;
                S_REQUEST: state <= !seq_req ? S_IDLE : (mreqin ? S_ACTIVE : S_REQUEST);
                default:   state <= seq_req ? S_ACTIVE : S_IDLE;
            endcase

            if (seq_req && !seq_run) begin
                mread    <= fetch;
                mload    <= store && !fetch;
                suppress <= 1'b1;
            end

            if (in_st0) begin
                if (tp.t01) begin
                    mread <= 1'b0;
                    mload <= 1'b0;
                end else if (tp.t04) begin
                    mdt <= {regs.rw_bank[14], 1'b0, regs.rw_bank[13:0]};  // Bank onto S/BB
                end else if (tp.t08) begin
                    mdt <= regs.rw_addr;
                end else if (tp.t05 || tp.t09) begin
                    mdt <= '0;
                end
            end else if (in_st1) begin
                if ((tp.t04 || tp.t09) && store && !fetch) begin
                    mdt <= regs.rw_data;
                end else if (tp.t05 || tp.t10) begin
                    mdt <= '0;
                end else if (tp.t11) begin
                    state    <= S_IDLE;
                    suppress <= 1'b0;
                end
            end
        end
    end

    a_rd_ld_excl: assert property (@(posedge SIM_CLK) disable iff (!rst_n)
        !(mread && mload));

    a_tp_onehot: assert property (@(posedge SIM_CLK) disable iff (!rst_n)
        $onehot0(tp));

endmodule

// ==== source/agc_monitor.sv ====
module agc_monitor import agc_bus_pkg::*, mon_reg_pkg::*; (
    input  logic     SIM_CLK,
    input  logic     rst_n,
    input  logic     tdi,
    input  ir_t      ir,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    output logic     tdo,
    input  word_t    wbus,
    input  tp_t      tp,
    input  stage_t   stage,
    input  sq_t      sq,
    input  wstrobe_t wstr,
    input  logic     mnisq,
    input  logic     mreqin,
    output word_t    mdt,
    output logic     mread,
    output logic     mload,
    output logic     mstp,
    output logic     mstrt,
    output logic     nhalga
);

    mon_file_t  regs;
    shadow_t    shadow;
    logic       upd;
    ir_t        upd_ir;
    scan_word_u upd_word;
    logic       hit;
    logic       suppress;                 // MSTP held off while stepping or sequencing
    logic       rw_load;
    logic       step_done;
    logic       fetch_done;
    logic       store_done;

    scan_port u_scan (.SIM_CLK, .rst_n, .tdi, .ir, .capture, .shift, .update,
                      .regs, .shadow, .tdo, .upd, .upd_ir, .upd_word);

    mon_regs u_regs (.SIM_CLK, .rst_n, .upd, .upd_ir, .upd_word, .wbus, .rw_load,
                     .step_done, .fetch_done, .store_done, .hit, .regs);

    cpu_shadow u_shadow (.SIM_CLK, .rst_n, .wbus, .wstr, .sq, .shadow);

    break_detect u_break (.shadow, .regs, .mnisq, .hit);

    seq_ctrl u_seq (.SIM_CLK, .rst_n, .regs, .tp, .stage, .mnisq, .mreqin, .mdt,
                    .mread, .mload, .suppress, .rw_load, .step_done, .fetch_done,
                    .store_done);

    assign mstp   = regs.control.mstp && !suppress;
    assign mstrt  = regs.control.mstrt;
    assign nhalga = regs.control.nhalga;

endmodule

// ==== bench/tb_agc_monitor.sv ====
module tb_agc_monitor import agc_bus_pkg::*, mon_reg_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic     SIM_CLK;
    logic     rst_n;
    logic     tdi;
    ir_t      ir;
    logic     capture;
    logic     shift;
    logic     update;
    logic     tdo;
    word_t    wbus;
    tp_t      tp;
    stage_t   stage;
    sq_t      sq;
    wstrobe_t wstr;
    logic     mnisq;
    logic     mreqin;
    word_t    mdt;
    logic     mread;
    logic     mload;
    logic     mstp;
    logic     mstrt;
    logic     nhalga;

    word_t       reg_model [0:31];        // Expected register contents by instruction code
    int unsigned lcg_state = 6;
    logic        mdt_check_en = 1'b0;
    logic        seq_is_store = 1'b0;
    word_t       exp_mdt = '0;

    agc_monitor dut (.*);

    always #10 SIM_CLK = ~SIM_CLK;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_control(input control_t got, input control_t exp);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t: control got %h expected %h", $time, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    function automatic word_t next_rand();
        lcg_state = lcg_state * 1103515245 + 12345;
        return lcg_state[30:15];
    endfunction

    // Shadow rule per strobe index k in wstrobe_t order from wag
    function automatic word_t shadow_ref(input int k, input word_t old, input word_t bus);
        word_t r;
        r = old;
        case (k)
            4: begin
                r[14] = bus[15];
                r[13:10] = bus[13:10];
                r[2:0] = bus[2:0];
            end
            5: r[2:0] = bus[10:8];
            6: begin
                r[14] = bus[15];
                r[13:10] = bus[13:10];
            end
            9: r = {4'b0, bus[11:0]};
            default: r = bus;
        endcase
        return r;
    endfunction

    function automatic ir_t strobe_reg(input int k);
        case (k)
            0: return IR_REG_A;
            1: return IR_REG_L;
            2: return IR_REG_Q;
            3: return IR_REG_Z;
            4, 5, 6: return IR_REG_BB;
            7, 8: return IR_REG_G;
            9: return IR_REG_S;
            default: return IR_REG_B;
        endcase
    endfunction

    function automatic logic break_ref(input word_t s, input word_t bb, input word_t baddr,
                                       input word_t bbank);
        logic bank_ok;
        bank_ok = (bb[14:13] == FEB_BANKS) ? (bb[14:4] == bbank[14:4])
                                           : (bb[14:10] == bbank[14:10]);
        return (s[11:0] == baddr[11:0]) && (s[11:10] != FIXED_SWITCHED || bank_ok);
    endfunction

    function automatic word_t mdt_ref(input stage_t st, input tp_t t, input logic is_store,
                                      input word_t bank, input word_t addr, input word_t data,
                                      input word_t prev);
        if (st == STAGE_0) begin
            if (t.t04) return {bank[14], 1'b0, bank[13:0]};
            if (t.t08) return addr;
            if (t.t05 || t.t09) return '0;
        end else if (st == STAGE_1) begin
            if ((t.t04 || t.t09) && is_store) return data;
            if (t.t05 || t.t10) return '0;
        end
        return prev;
    endfunction

    // Compare mdt one edge after each timepulse of a sequence
    always @(posedge SIM_CLK) begin
        if (mdt_check_en && tp != '0) begin
            exp_mdt = mdt_ref(stage, tp, seq_is_store, reg_model[IR_RWBANK],
                              reg_model[IR_RWADDR], reg_model[IR_RWDATA], exp_mdt);
            #1;
            check_word(mdt, exp_mdt, "mdt");
        end
    end

    task automatic tick();
        @(posedge SIM_CLK);
        #2;
    endtask

    task automatic scan_write(input ir_t code, input word_t w);
        tick();
        ir = code;
        shift = 1'b1;
        tdi = w[0];
        for (int i = 1; i < 16; i++) begin
            tick();
            tdi = w[i];
        end
        tick();
        shift = 1'b0;
        update = 1'b1;
        tick();
        update = 1'b0;
        tick();                           // Register written at this edge
    endtask

    task automatic scan_read(input ir_t code, output word_t w);
        tick();
        ir = code;
        capture = 1'b1;
        tick();
        capture = 1'b0;
        tdi = 1'b0;
        for (int i = 0; i < 16; i++) begin
            w[i] = tdo;
            shift = 1'b1;
            tick();
        end
        shift = 1'b0;
    endtask

    task automatic read_check(input ir_t code, input string name);
        word_t w;
        scan_read(code, w);
        check_word(w, reg_model[code], name);
    endtask

    task automatic write_control(input control_t c);
        scan_write(IR_CONTROL, {1'b1, c[14:0]});
    endtask

    task automatic pulse_tp(input int n);
        tick();
        tp = tp_t'(12'(1) << (n - 1));
        tick();
        tp = '0;
    endtask

    task automatic pulse_mnisq();
        tick();
        mnisq = 1'b1;
        tick();
        mnisq = 1'b0;
    endtask

    task automatic apply_strobe(input int k, input word_t bus);
        tick();
        wbus = bus;
        wstr = wstrobe_t'(11'(1) << (10 - k));
        tick();
        wstr = '0;
        reg_model[strobe_reg(k)] = shadow_ref(k, reg_model[strobe_reg(k)], bus);
    endtask

    // Output select is 0 for mstp, 1 for mread, 2 for mload
    task automatic wait_out(input int which, input logic v, input string what);
        int n;
        logic cur;
        n = 0;
        cur = (which == 0) ? mstp : (which == 1) ? mread : mload;
        while (cur !== v) begin
            tick();
            n++;
            if (n > 50) fail_now({"Timed out waiting for ", what});
            cur = (which == 0) ? mstp : (which == 1) ? mread : mload;
        end
    endtask

    task automatic wait_seq_clear(input string what);
        word_t w;
        int n;
        n = 0;
        scan_read(IR_CONTROL, w);
        while (w[5] || w[6]) begin
            n++;
            if (n > 8) fail_now({"Timed out waiting for the ", what, " bit to clear"});
            scan_read(IR_CONTROL, w);
        end
    endtask

    task automatic run_step(input logic st);
        control_t c;
        word_t w;
        c = '0;
        c.mstp = 1'b1;
        c.step = 1'b1;
        c.step_type = st;
        write_control(c);
        tick();
        tick();
        check_bit(mstp, 1'b0, "mstp while stepping");
        check_bit(mstrt, 1'b0, "mstrt");
        check_bit(nhalga, 1'b0, "nhalga");
        if (st == STEP_MCT) pulse_tp(1);
        else pulse_mnisq();
        wait_out(0, 1'b1, "mstp after the step");
        scan_read(IR_CONTROL, w);
        c.step = 1'b0;
        check_control(control_t'(w), c);
    endtask

    task automatic try_break(input word_t bb_bus, input word_t bank);
        control_t c;
        logic exp;
        apply_strobe(4, bb_bus);
        apply_strobe(9, 16'o2345);         // S in the fixed-switched window
        scan_write(IR_BRKADDR, 16'o102345);
        scan_write(IR_BRKBANK, {1'b1, bank[14:0]});
        reg_model[IR_BRKADDR] = 16'o2345;
        reg_model[IR_BRKBANK] = {1'b0, bank[14:0]};
        c = '0;
        c.break_inst = 1'b1;
        write_control(c);
        pulse_mnisq();
        exp = break_ref(reg_model[IR_REG_S], reg_model[IR_REG_BB], reg_model[IR_BRKADDR],
                        reg_model[IR_BRKBANK]);
        check_bit(mstp, exp, "mstp on breakpoint");
        write_control('0);
    endtask

    task automatic run_sequence(input logic store_seq);
        word_t fw;
        mreqin = 1'b1;
        seq_is_store = store_seq;
        mdt_check_en = 1'b1;
        stage = STAGE_0;
        for (int n = 1; n <= 12; n++) begin
            pulse_tp(n);
            if (n == 1) check_bit(store_seq ? mload : mread, 1'b0, "mread or mload at t01");
        end
        stage = STAGE_1;
        for (int n = 1; n <= 12; n++) begin
            if (n == 7 && !store_seq) begin
                fw = next_rand();
                wbus = fw;
                reg_model[IR_RWDATA] = fw;
            end
            pulse_tp(n);
        end
        mdt_check_en = 1'b0;
        mreqin = 1'b0;
    endtask

    initial begin
        word_t w;
        control_t c;
        ir_t codes [4];
        SIM_CLK = 1'b0;
        rst_n = 1'b0;
        tdi = 1'b0;
        ir = IR_BYPASS;
        capture = 1'b0;
        shift = 1'b0;
        update = 1'b0;
        wbus = '0;
        tp = '0;
        stage = STAGE_0;
        sq = '0;
        wstr = '0;
        mnisq = 1'b0;
        mreqin = 1'b0;
        codes = '{IR_BRKBANK, IR_BRKADDR, IR_RWBANK, IR_RWADDR};
        for (int i = 0; i < 32; i++) reg_model[i] = '0;
        repeat (4) @(posedge SIM_CLK);
        #2 rst_n = 1'b1;
        check_word(mdt, '0, "mdt after reset");
        check_bit(mread, 1'b0, "mread after reset");
        check_bit(mload, 1'b0, "mload after reset");
        check_bit(mstp, 1'b0, "mstp after reset");
        check_bit(mstrt, 1'b0, "mstrt after reset");
        check_bit(nhalga, 1'b0, "nhalga after reset");

        // Host registers, write enable and bypass
        for (int k = 0; k < 4; k++) begin
            w = next_rand();
            scan_write(codes[k], {1'b1, w[14:0]});
            reg_model[codes[k]] = {1'b0, w[14:0]};
            read_check(codes[k], "register with write enable");
            w = next_rand();
            scan_write(codes[k], {1'b0, w[14:0]});
            read_check(codes[k], "register without write enable");
        end
        w = next_rand();
        scan_write(IR_RWDATA, {1'b0, w[14:0]});
        reg_model[IR_RWDATA] = {reg_model[IR_RWDATA][15], w[14:0]};
        read_check(IR_RWDATA, "rw_data");
        tick();
        ir = IR_BYPASS;
        shift = 1'b1;
        for (int i = 0; i < 16; i++) begin
            w = next_rand();
            tdi = w[0];
            tick();
            tdi = ~w[0];                  // tdo follows the bypass flop, not tdi
            check_bit(tdo, w[0], "tdo in bypass");
        end
        shift = 1'b0;

        // Shadow registers
        for (int k = 0; k < 11; k++) begin
            apply_strobe(k, next_rand());
            read_check(strobe_reg(k), "shadow register");
        end
        w = next_rand();
        sq = sq_t'(w[6:0]);
        scan_read(IR_REG_SQ, w);
        check_word(w, {sq.sqext, sq.sq16, sq.sq14, sq.sq13, sq.sq12, sq.sq11, sq.sq10, 9'b0},
                   "sq word");

        // Control outputs and stepping
        c = '0;
        c.mstp = 1'b1;
        c.mstrt = 1'b1;
        c.nhalga = 1'b1;
        write_control(c);
        check_bit(mstp, 1'b1, "mstp");
        check_bit(mstrt, 1'b1, "mstrt");
        check_bit(nhalga, 1'b1, "nhalga");
        run_step(STEP_MCT);
        run_step(STEP_INST);
        write_control('0);

        // Breakpoint match, then bank mismatch, then FEB mismatch
        try_break(16'h1400, 16'h1400);
        try_break(16'h1400, 16'h0c00);
        try_break(16'ha000, 16'h6020);

        // FETCH
        c = '0;
        c.fetch = 1'b1;
        write_control(c);
        wait_out(1, 1'b1, "mread to rise");
        check_bit(mload, 1'b0, "mload during fetch");
        run_sequence(1'b0);
        wait_seq_clear("fetch");
        read_check(IR_RWDATA, "rw_data after fetch");

        // STORE
        w = next_rand();
        scan_write(IR_RWDATA, w);
        reg_model[IR_RWDATA] = {reg_model[IR_RWDATA][15], w[14:0]};
        c = '0;
        c.store = 1'b1;
        c.mstp = 1'b1;
        write_control(c);
        wait_out(2, 1'b1, "mload to rise");
        check_bit(mstp, 1'b0, "mstp during store");
        run_sequence(1'b1);
        wait_out(0, 1'b1, "mstp after the store");
        wait_seq_clear("store");

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/agc_bus_pkg.sv
source/mon_reg_pkg.sv
source/scan_port.sv
source/mon_regs.sv
source/cpu_shadow.sv
source/break_detect.sv
source/seq_ctrl.sv
source/agc_monitor.sv
bench/tb_agc_monitor.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_agc_monitor
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
